// ==== include/mini_cpu_settings.svh ====
// ----------------------------------------------------------
// Core sizing. Decoder field positions assume a 16-bit word
// ----------------------------------------------------------

`ifndef MINI_CPU_SETTINGS_SVH
`define MINI_CPU_SETTINGS_SVH

// Data, instruction and PC width
`define CPU_WORD_W      16

// Architectural registers
`define CPU_REG_COUNT   8

// Data memory words, word addressed
`define CPU_DMEM_DEPTH  256

`endif

// ==== rtl/mini_cpu_pkg.sv ====
// ----------------------------------------------------------
// Types shared by the core. An all-zero payload is a NOP
// ----------------------------------------------------------
`default_nettype none

`include "mini_cpu_settings.svh"

package mini_cpu_pkg;

   typedef logic [`CPU_WORD_W-1:0]            word_t;
   typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

   // 9 to 14 are illegal
   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_XOR  = 4'd4,
      OP_ADDI = 4'd5,
      OP_LBI  = 4'd6,
      OP_LD   = 4'd7,
      OP_ST   = 4'd8,
      OP_HALT = 4'd15
   } opcode_e;

   typedef enum logic [1:0] {
      FWD_RF  = 2'd0,
      FWD_MEM = 2'd1,
      FWD_WB  = 2'd2
   } fwd_sel_e;

   typedef enum logic {
      WB_ALU = 1'b0,
      WB_MEM = 1'b1
   } wb_sel_e;

   typedef struct packed {
      word_t instr;
      word_t pc;
   } if_id_t;

   typedef struct packed {
      word_t    pc;
      word_t    op_a;
      word_t    op_b;
      word_t    imm;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      opcode_e  alu_op;
      logic     uses_rs;
      logic     uses_rt;
      logic     reg_we;
      logic     mem_rd;
      logic     mem_wr;
      wb_sel_e  wb_sel;
      logic     halt;
   } id_ex_t;

   typedef struct packed {
      word_t    alu_res;
      word_t    st_data;
      reg_idx_t rd;
      logic     reg_we;
      logic     mem_rd;
      logic     mem_wr;
      wb_sel_e  wb_sel;
      logic     halt;
   } ex_mem_t;

   typedef struct packed {
      word_t    alu_res;
      word_t    mem_data;
      reg_idx_t rd;
      logic     reg_we;
      wb_sel_e  wb_sel;
      logic     halt;
   } mem_wb_t;

endpackage

`default_nettype wire

// ==== rtl/pipe_stage.sv ====
// ----------------------------------------------------------
// Stage register. Hold wins over bubble, bubble loads zeros
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module pipe_stage #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     hold,
   input  logic     bubble,
   input  payload_t d,
   output payload_t q
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         q <= '0;
      end else if (!hold) begin
         // Zero payload decodes as a NOP
         if (bubble) begin
            q <= '0;
         end else begin
            q <= d;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// ----------------------------------------------------------
// Register file with write-through on both read ports
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mini_cpu_settings.svh"

module reg_file (
   input  logic                   clk,
   input  logic                   arst_n,
   input  mini_cpu_pkg::reg_idx_t rd_idx_a,
   input  mini_cpu_pkg::reg_idx_t rd_idx_b,
   output mini_cpu_pkg::word_t    rd_data_a,
   output mini_cpu_pkg::word_t    rd_data_b,
   input  logic                   wr_en,
   input  mini_cpu_pkg::reg_idx_t wr_idx,
   input  mini_cpu_pkg::word_t    wr_data
);

   mini_cpu_pkg::word_t regs [`CPU_REG_COUNT];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // Writeback in the same cycle is seen by decode
   assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
   assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

`default_nettype wire

// ==== rtl/decode_unit.sv ====
// ----------------------------------------------------------
// Decoder. Illegal opcodes travel on as NOPs
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mini_cpu_settings.svh"

module decode_unit (
   input  mini_cpu_pkg::word_t    instr,
   input  mini_cpu_pkg::word_t    pc,
   input  mini_cpu_pkg::word_t    rd_data_a,
   input  mini_cpu_pkg::word_t    rd_data_b,
   output mini_cpu_pkg::reg_idx_t rd_idx_a,
   output mini_cpu_pkg::reg_idx_t rd_idx_b,
   output mini_cpu_pkg::id_ex_t   id_ex,
   output logic                   illegal,
   output logic                   is_halt
);

   mini_cpu_pkg::opcode_e op;
   mini_cpu_pkg::word_t   imm6;
   mini_cpu_pkg::word_t   imm9;

   assign op   = mini_cpu_pkg::opcode_e'(instr[15:12]);
   assign imm6 = {{(`CPU_WORD_W-6){instr[5]}}, instr[5:0]};
   assign imm9 = {{(`CPU_WORD_W-9){instr[8]}}, instr[8:0]};

   // Store data is read through the second port
   assign rd_idx_a = instr[8:6];
   assign rd_idx_b = (op == mini_cpu_pkg::OP_ST) ? instr[11:9] : instr[5:3];
   assign is_halt  = (op == mini_cpu_pkg::OP_HALT);

   always_comb begin
      id_ex        = '0;
      illegal      = 1'b0;
      id_ex.pc     = pc;
      id_ex.op_a   = rd_data_a;
      id_ex.op_b   = rd_data_b;
      id_ex.rs     = rd_idx_a;
      id_ex.rt     = rd_idx_b;
      id_ex.rd     = instr[11:9];
      id_ex.alu_op = op;
      case (op)
         mini_cpu_pkg::OP_NOP: begin
         end
         mini_cpu_pkg::OP_ADD, mini_cpu_pkg::OP_SUB,
         mini_cpu_pkg::OP_AND, mini_cpu_pkg::OP_XOR: begin
            id_ex.uses_rs = 1'b1;
            id_ex.uses_rt = 1'b1;
            id_ex.reg_we  = 1'b1;
         end
         mini_cpu_pkg::OP_ADDI: begin
            id_ex.imm     = imm6;
            id_ex.uses_rs = 1'b1;
            id_ex.reg_we  = 1'b1;
         end
         mini_cpu_pkg::OP_LBI: begin
            id_ex.imm    = imm9;
            id_ex.reg_we = 1'b1;
         end
         mini_cpu_pkg::OP_LD: begin
            id_ex.imm     = imm6;
            id_ex.uses_rs = 1'b1;
            id_ex.reg_we  = 1'b1;
            id_ex.mem_rd  = 1'b1;
            id_ex.wb_sel  = mini_cpu_pkg::WB_MEM;
         end
         mini_cpu_pkg::OP_ST: begin
            id_ex.imm     = imm6;
            id_ex.uses_rs = 1'b1;
            id_ex.uses_rt = 1'b1;
            id_ex.mem_wr  = 1'b1;
         end
         mini_cpu_pkg::OP_HALT: begin
            id_ex.halt = 1'b1;
         end
         default: begin
            id_ex.alu_op = mini_cpu_pkg::OP_NOP;
            illegal      = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
// ----------------------------------------------------------
// Forwarding selects for EX and the load-use stall for ID
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
   input  mini_cpu_pkg::reg_idx_t id_rs,
   input  mini_cpu_pkg::reg_idx_t id_rt,
   input  logic                   id_uses_rs,
   input  logic                   id_uses_rt,
   input  mini_cpu_pkg::id_ex_t   ex_stage,
   input  mini_cpu_pkg::ex_mem_t  mem_stage,
   input  mini_cpu_pkg::mem_wb_t  wb_stage,
   output mini_cpu_pkg::fwd_sel_e fwd_a,
   output mini_cpu_pkg::fwd_sel_e fwd_b
   ,
   output logic                   stall
);

   logic mem_fwd_ok;
   logic ex_is_load;

   // A load in EX/MEM has no data yet
   assign mem_fwd_ok = mem_stage.reg_we & ~mem_stage.mem_rd;
   assign ex_is_load = ex_stage.mem_rd & ex_stage.reg_we;

   always_comb begin
      fwd_a = mini_cpu_pkg::FWD_RF;
      if (ex_stage.uses_rs) begin
         if (mem_fwd_ok && mem_stage.rd == ex_stage.rs) begin
            fwd_a = mini_cpu_pkg::FWD_MEM;
         end else if (wb_stage.reg_we && wb_stage.rd == ex_stage.rs) begin
            fwd_a = mini_cpu_pkg::FWD_WB;
         end
      end
   end

   always_comb begin
      fwd_b = mini_cpu_pkg::FWD_RF;
      if (ex_stage.uses_rt) begin
         if (mem_fwd_ok && mem_stage.rd == ex_stage.rt) begin
            fwd_b = mini_cpu_pkg::FWD_MEM;
         end else if (wb_stage.reg_we && wb_stage.rd == ex_stage.rt) begin
            fwd_b = mini_cpu_pkg::FWD_WB;
         end
      end
   end

   // One bubble lets the load data reach MEM/WB
   assign stall = ex_is_load &
                  ((id_uses_rs & (id_rs == ex_stage.rd)) |
                   (id_uses_rt & (id_rt == ex_stage.rd)));

endmodule

`default_nettype wire

// ==== rtl/execute_unit.sv ====
// ----------------------------------------------------------
// Operand forwarding and ALU. No flags or overflow detection
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
   input  mini_cpu_pkg::id_ex_t   ex_stage,
   input  mini_cpu_pkg::fwd_sel_e fwd_a,
   input  mini_cpu_pkg::fwd_sel_e fwd_b,
   input  mini_cpu_pkg::word_t    mem_result,
   input  mini_cpu_pkg::word_t    wb_result,
   output mini_cpu_pkg::ex_mem_t  ex_mem
);

   mini_cpu_pkg::word_t opnd_a;
   mini_cpu_pkg::word_t opnd_b;
   mini_cpu_pkg::word_t alu_res;

   always_comb begin
      case (fwd_a)
         mini_cpu_pkg::FWD_MEM: opnd_a = mem_result;
         mini_cpu_pkg::FWD_WB:  opnd_a = wb_result;
         default:               opnd_a = ex_stage.op_a;
      endcase
      case (fwd_b)
         mini_cpu_pkg::FWD_MEM: opnd_b = mem_result;
         mini_cpu_pkg::FWD_WB:  opnd_b = wb_result;
         default:               opnd_b = ex_stage.op_b;
      endcase
   end

   always_comb begin
      case (ex_stage.alu_op)
         mini_cpu_pkg::OP_ADD: alu_res = opnd_a + opnd_b;
         mini_cpu_pkg::OP_SUB: alu_res = opnd_a - opnd_b;
         mini_cpu_pkg::OP_AND: alu_res = opnd_a & opnd_b;
         mini_cpu_pkg::OP_XOR: alu_res = opnd_a ^ opnd_b;
         mini_cpu_pkg::OP_LBI: alu_res = ex_stage.imm;
         // Loads and stores share the address add
         mini_cpu_pkg::OP_ADDI, mini_cpu_pkg::OP_LD,
         mini_cpu_pkg::OP_ST:  alu_res = opnd_a + ex_stage.imm;
         default:              alu_res = '0;
      endcase
   end

   assign ex_mem = '{alu_res: alu_res, st_data: opnd_b, rd: ex_stage.rd,
                     reg_we: ex_stage.reg_we, mem_rd: ex_stage.mem_rd,
                     mem_wr: ex_stage.mem_wr, wb_sel: ex_stage.wb_sel,
                     halt: ex_stage.halt};

endmodule

`default_nettype wire

// ==== rtl/data_memory.sv ====
// ----------------------------------------------------------
// Data memory. Upper address bits are ignored
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mini_cpu_settings.svh"

module data_memory (
   input  logic                clk,
   input  logic                arst_n,
   input  mini_cpu_pkg::word_t addr,
   input  logic                wr_en,
   input  mini_cpu_pkg::word_t wr_data,
   output mini_cpu_pkg::word_t rd_data
);

   localparam int ADDR_W = $clog2(`CPU_DMEM_DEPTH);

   mini_cpu_pkg::word_t mem [`CPU_DMEM_DEPTH];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_en) begin
         mem[addr[ADDR_W-1:0]] <= wr_data;
      end
   end

   assign rd_data = mem[addr[ADDR_W-1:0]];

endmodule

`default_nettype wire

// ==== rtl/mini_cpu.sv ====
// ----------------------------------------------------------
// Five-stage core. Fetch port must answer in the same cycle
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mini_cpu (
   input  logic                   clk,
   input  logic                   arst_n,
   output mini_cpu_pkg::word_t    imem_addr,
   input  mini_cpu_pkg::word_t    imem_data,
   output logic                   retire_valid,
   output mini_cpu_pkg::reg_idx_t retire_reg,
   output mini_cpu_pkg::word_t    retire_data,
   output logic                   halted,
   output logic                   err
);

   mini_cpu_pkg::word_t    pc_q;
   logic                   fetch_stop_q;
   logic                   halted_q;
   logic                   err_q;
   logic                   fetch_hold;
   logic                   fetch_flush;

   mini_cpu_pkg::if_id_t   if_id_d, if_id_q;
   mini_cpu_pkg::id_ex_t   id_ex_d, id_ex_q;
   mini_cpu_pkg::ex_mem_t  ex_mem_d, ex_mem_q;
   mini_cpu_pkg::mem_wb_t  mem_wb_d, mem_wb_q;

   mini_cpu_pkg::reg_idx_t rd_idx_a, rd_idx_b;
   mini_cpu_pkg::word_t    rf_data_a, rf_data_b;
   logic                   illegal;
   logic                   is_halt;
   logic                   stall;
   mini_cpu_pkg::fwd_sel_e fwd_a, fwd_b;
   mini_cpu_pkg::word_t    dmem_rd_data;
   mini_cpu_pkg::word_t    wb_data;

   // Nothing behind a HALT is allowed into decode
   assign fetch_flush = is_halt | fetch_stop_q;
   assign fetch_hold  = stall | fetch_flush;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc_q <= '0;
      end else if (!fetch_hold) begin
         pc_q <= pc_q + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fetch_stop_q <= 1'b0;
         halted_q     <= 1'b0;
         err_q        <= 1'b0;
      end else begin
         fetch_stop_q <= fetch_stop_q | is_halt;
         halted_q     <= halted;
         // Only counts once the instruction really enters ID/EX
         err_q        <= err_q | (illegal & ~stall);
      end
   end

   assign imem_addr = pc_q;
   assign if_id_d   = '{instr: imem_data, pc: pc_q};

   pipe_stage #(.payload_t(mini_cpu_pkg::if_id_t)) if_id_reg (
      .clk(clk), .arst_n(arst_n), .hold(stall), .bubble(fetch_flush),
      .d(if_id_d), .q(if_id_q)
   );

   reg_file reg_file_inst (
      .clk(clk), .arst_n(arst_n),
      .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
      .rd_data_a(rf_data_a), .rd_data_b(rf_data_b),
      .wr_en(mem_wb_q.reg_we), .wr_idx(mem_wb_q.rd), .wr_data(wb_data)
   );

   decode_unit decode_unit_inst (
      .instr(if_id_q.instr), .pc(if_id_q.pc),
      .rd_data_a(rf_data_a), .rd_data_b(rf_data_b),
      .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
      .id_ex(id_ex_d), .illegal(illegal), .is_halt(is_halt)
   );

   hazard_unit hazard_unit_inst (
      .id_rs(rd_idx_a), .id_rt(rd_idx_b),
      .id_uses_rs(id_ex_d.uses_rs), .id_uses_rt(id_ex_d.uses_rt),
      .ex_stage(id_ex_q), .mem_stage(ex_mem_q), .wb_stage(mem_wb_q),
      .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
   );

   pipe_stage #(.payload_t(mini_cpu_pkg::id_ex_t)) id_ex_reg (
      .clk(clk), .arst_n(arst_n), .hold(1'b0), .bubble(stall),
      .d(id_ex_d), .q(id_ex_q)
   );

   execute_unit execute_unit_inst (
      .ex_stage(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b),
      .mem_result(ex_mem_q.alu_res), .wb_result(wb_data),
      .ex_mem(ex_mem_d)
   );

   pipe_stage #(.payload_t(mini_cpu_pkg::ex_mem_t)) ex_mem_reg (
      .clk(clk), .arst_n(arst_n), .hold(1'b0), .bubble(1'b0),
      .d(ex_mem_d), .q(ex_mem_q)
   );

   data_memory data_memory_inst (
      .clk(clk), .arst_n(arst_n), .addr(ex_mem_q.alu_res),
      .wr_en(ex_mem_q.mem_wr), .wr_data(ex_mem_q.st_data),
      .rd_data(dmem_rd_data)
   );

   assign mem_wb_d = '{alu_res: ex_mem_q.alu_res, mem_data: dmem_rd_data,
                       rd: ex_mem_q.rd, reg_we: ex_mem_q.reg_we,
                       wb_sel: ex_mem_q.wb_sel, halt: ex_mem_q.halt};

   pipe_stage #(.payload_t(mini_cpu_pkg::mem_wb_t)) mem_wb_reg (
      .clk(clk), .arst_n(arst_n), .hold(1'b0), .bubble(1'b0),
      .d(mem_wb_d), .q(mem_wb_q)
   );

   assign wb_data = (mem_wb_q.wb_sel == mini_cpu_pkg::WB_MEM) ?
                    mem_wb_q.mem_data : mem_wb_q.alu_res;

   assign retire_valid = mem_wb_q.reg_we;
   assign retire_reg   = mem_wb_q.rd;
   assign retire_data  = wb_data;

   // High from the cycle the HALT sits in writeback
   assign halted = halted_q | mem_wb_q.halt;
   assign err    = err_q;

endmodule

`default_nettype wire

// ==== verification/mini_cpu_sva.sv ====
// ----------------------------------------------------------
// Pipeline control rules, bound into mini_cpu
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mini_cpu_sva (
   input logic clk,
   input logic arst_n,
   input logic stall,
   input logic halted,
   input logic retire_valid,
   input logic err
);

   int fail_count = 0;

   // Load-use bubble is a single cycle
   stall_one_cycle: assert property (
      @(posedge clk) disable iff (!arst_n) stall |=> !stall)
      else begin
         fail_count++;
         $error("stall high for two cycles in a row");
      end

   halted_sticky: assert property (
      @(posedge clk) disable iff (!arst_n) halted |=> halted)
      else begin
         fail_count++;
         $error("halted fell without a reset");
      end

   no_retire_after_halt: assert property (
      @(posedge clk) disable iff (!arst_n) halted |=> !retire_valid)
      else begin
         fail_count++;
         $error("retire_valid high after halted");
      end

   clean_after_reset: assert property (
      @(posedge clk) $rose(arst_n) |-> (!err && !halted))
      else begin
         fail_count++;
         $error("err or halted high right after reset");
      end

endmodule

`default_nettype wire

// ==== verification/mini_cpu_tb.sv ====
// ----------------------------------------------------------
// Random programs checked against an in-order ISA model
// ROM holds 256 words, unused entries are HALT
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "mini_cpu_settings.svh"

module mini_cpu_tb;

   localparam logic [3:0] OPC_NOP  = 4'd0;
   localparam logic [3:0] OPC_ADD  = 4'd1;
   localparam logic [3:0] OPC_SUB  = 4'd2;
   localparam logic [3:0] OPC_AND  = 4'd3;
   localparam logic [3:0] OPC_XOR  = 4'd4;
   localparam logic [3:0] OPC_ADDI = 4'd5;
   localparam logic [3:0] OPC_LBI  = 4'd6;
   localparam logic [3:0] OPC_LD   = 4'd7;
   localparam logic [3:0] OPC_ST   = 4'd8;
   localparam logic [3:0] OPC_HALT = 4'd15;
   localparam int TIMEOUT_CYCLES   = 400;

   logic                   clk;
   logic                   arst_n;
   logic [`CPU_WORD_W-1:0] imem_addr;
   logic [`CPU_WORD_W-1:0] imem_data;
   logic                   retire_valid;
   logic [2:0]             retire_reg;
   logic [`CPU_WORD_W-1:0] retire_data;
   logic                   halted;
   logic                   err;

   logic [`CPU_WORD_W-1:0] rom [256];
   logic [`CPU_WORD_W-1:0] model_regs [`CPU_REG_COUNT];
   logic [`CPU_WORD_W-1:0] model_mem [`CPU_DMEM_DEPTH];
   logic [2:0]             exp_reg_q [$];
   logic [`CPU_WORD_W-1:0] exp_data_q [$];

   integer seed;
   int     prog_len;
   int     error_count;
   int     test_count;
   int     failed_tests;
   int     retire_count;
   int     model_writes;

   assign imem_data = rom[imem_addr[7:0]];

   mini_cpu mini_cpu_inst (
      .clk(clk), .arst_n(arst_n),
      .imem_addr(imem_addr), .imem_data(imem_data),
      .retire_valid(retire_valid), .retire_reg(retire_reg),
      .retire_data(retire_data), .halted(halted), .err(err)
   );

   bind mini_cpu mini_cpu_sva mini_cpu_sva_inst (
      .clk(clk), .arst_n(arst_n), .stall(stall), .halted(halted),
      .retire_valid(retire_valid), .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic logic [2:0] rand_reg();
      return 3'(rand_below(8));
   endfunction

   function automatic logic [15:0] alu_instr(input logic [3:0] op, input logic [2:0] rd,
                                             input logic [2:0] rs, input logic [2:0] rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic logic [15:0] imm_instr(input logic [3:0] op, input logic [2:0] rd,
                                             input logic [2:0] rs, input logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   function automatic logic [15:0] lbi_instr(input logic [2:0] rd, input logic [8:0] imm);
      return {OPC_LBI, rd, imm};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic new_program();
      for (int i = 0; i < 256; i++) begin
         rom[i] = {OPC_HALT, 12'h000};
      end
      prog_len = 0;
   endtask

   task automatic put_instr(input logic [15:0] instr);
      rom[prog_len] = instr;
      prog_len++;
   endtask

   task automatic put_nops(input int n);
      repeat (n) put_instr({OPC_NOP, 12'h000});
   endtask

   task automatic seed_registers();
      for (int r = 0; r < 8; r++) begin
         put_instr(lbi_instr(3'(r), 9'(rand_below(512))));
      end
   endtask

   task automatic record_write(input logic [2:0] rd, input logic [15:0] value);
      model_regs[rd] = value;
      exp_reg_q.push_back(rd);
      exp_data_q.push_back(value);
      model_writes++;
   endtask

   // Sequential execution of the ROM up to the first HALT
   task automatic run_model();
      logic [15:0] ins;
      logic [3:0]  op;
      logic [2:0]  rd;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] imm6;
      logic [7:0]  addr;
      int          pc;
      bit          done;
      for (int i = 0; i < `CPU_REG_COUNT; i++) model_regs[i] = '0;
      for (int i = 0; i < `CPU_DMEM_DEPTH; i++) model_mem[i] = '0;
      exp_reg_q.delete();
      exp_data_q.delete();
      model_writes = 0;
      pc = 0;
      done = 1'b0;
      while (!done && pc < 256) begin
         ins  = rom[pc];
         op   = ins[15:12];
         rd   = ins[11:9];
         a    = model_regs[ins[8:6]];
         b    = model_regs[ins[5:3]];
         imm6 = {{10{ins[5]}}, ins[5:0]};
         addr = 8'(a + imm6);
         case (op)
            OPC_ADD:  record_write(rd, a + b);
            OPC_SUB:  record_write(rd, a - b);
            OPC_AND:  record_write(rd, a & b);
            OPC_XOR:  record_write(rd, a ^ b);
            OPC_ADDI: record_write(rd, a + imm6);
            OPC_LBI:  record_write(rd, {{7{ins[8]}}, ins[8:0]});
            OPC_LD:   record_write(rd, model_mem[addr]);
            OPC_ST:   model_mem[addr] = model_regs[rd];
            OPC_HALT: done = 1'b1;
            default: begin
            end
         endcase
         pc++;
      end
   endtask

   always @(negedge clk) begin
      if (arst_n === 1'b1 && retire_valid === 1'b1) begin
         retire_count++;
         if (exp_reg_q.size() == 0) begin
            $display("Retire of r%0d with no write left in the model", retire_reg);
            error_count++;
         end else begin
            check_value("retire_reg", 32'(retire_reg), 32'(exp_reg_q.pop_front()));
            check_value("retire_data", 32'(retire_data), 32'(exp_data_q.pop_front()));
         end
      end
   end

   task automatic apply_reset();
      @(posedge clk);
      #1 arst_n = 1'b0;
      repeat (8) @(posedge clk);
      #1 arst_n = 1'b1;
   endtask

   task automatic wait_for_err(output bit ok);
      int cyc;
      cyc = 0;
      while (err !== 1'b1 && cyc < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cyc++;
      end
      ok = (err === 1'b1);
   endtask

   task automatic wait_for_halt(input bit err_must_stay_low, output bit ok);
      int cyc;
      bit err_seen;
      cyc = 0;
      err_seen = 1'b0;
      while (halted !== 1'b1 && cyc < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cyc++;
         if (err_must_stay_low && err === 1'b1 && !err_seen) begin
            $display("err rose during a program with legal opcodes only");
            error_count++;
            err_seen = 1'b1;
         end
      end
      ok = (halted === 1'b1);
   endtask

   task automatic run_test(input string name, input bit expect_err);
      int errors_before;
      bit ok;
      errors_before = error_count;
      run_model();
      retire_count = 0;
      apply_reset();
      // Fetch starts from word zero
      check_value("imem_addr", 32'(imem_addr), 32'h0);
      if (expect_err) begin
         wait_for_err(ok);
         if (!ok) begin
            $display("err did not rise within %0d cycles", TIMEOUT_CYCLES);
            error_count++;
         end
      end
      wait_for_halt(!expect_err, ok);
      if (!ok) begin
         $display("halted did not rise within %0d cycles", TIMEOUT_CYCLES);
         error_count++;
      end
      // Anything still in flight after HALT would show up here
      repeat (4) @(negedge clk);
      check_value("retire_count", 32'(retire_count), 32'(model_writes));
      check_value("err", 32'(err), 32'(expect_err));
      test_count++;
      if (error_count == errors_before) begin
         $display("Test %s: ok, %0d register writes", name, model_writes);
      end else begin
         failed_tests++;
         $display("Test %s: failed with %0d errors", name, error_count - errors_before);
      end
   endtask

   task automatic alu_program();
      new_program();
      seed_registers();
      put_nops(3);
      repeat (12) begin
         put_instr(alu_instr(4'(OPC_ADD + rand_below(4)), rand_reg(), rand_reg(), rand_reg()));
         put_nops(3);
      end
   endtask

   task automatic immediate_program();
      new_program();
      put_instr(lbi_instr(3'd3, 9'h100));
      put_instr(imm_instr(OPC_ADDI, 3'd4, 3'd3, 6'h20));
      repeat (16) begin
         if (rand_below(2) == 0) begin
            put_instr(lbi_instr(rand_reg(), 9'(rand_below(512))));
         end else begin
            put_instr(imm_instr(OPC_ADDI, rand_reg(), rand_reg(), 6'(rand_below(64))));
         end
      end
   endtask

   task automatic forwarding_program();
      logic [2:0] prev1;
      logic [2:0] prev2;
      logic [2:0] src;
      logic [2:0] dst;
      new_program();
      seed_registers();
      prev1 = 3'd7;
      prev2 = 3'd6;
      repeat (24) begin
         src = (rand_below(2) == 0) ? prev1 : prev2;
         dst = rand_reg();
         if (rand_below(4) == 0) begin
            put_instr(imm_instr(OPC_ADDI, dst, src, 6'(rand_below(64))));
         end else if (rand_below(2) == 0) begin
            put_instr(alu_instr(4'(OPC_ADD + rand_below(4)), dst, src, rand_reg()));
         end else begin
            put_instr(alu_instr(4'(OPC_ADD + rand_below(4)), dst, rand_reg(), src));
         end
         prev2 = prev1;
         prev1 = dst;
      end
   endtask

   task automatic memory_program();
      logic [2:0] base;
      logic [2:0] loaded;
      logic [5:0] offset;
      new_program();
      seed_registers();
      repeat (6) begin
         base   = rand_reg();
         loaded = rand_reg();
         offset = 6'(rand_below(64));
         put_instr(imm_instr(OPC_ST, rand_reg(), base, offset));
         put_instr(imm_instr(OPC_LD, loaded, base, offset));
         // Load-use on the very next instruction
         put_instr(alu_instr(OPC_ADD, rand_reg(), loaded, rand_reg()));
         loaded = rand_reg();
         put_instr(imm_instr(OPC_LD, loaded, rand_reg(), 6'(rand_below(64))));
         put_instr(imm_instr(OPC_ST, loaded, rand_reg(), 6'(rand_below(64))));
      end
   endtask

   task automatic halt_program();
      new_program();
      seed_registers();
      repeat (6) begin
         put_instr(alu_instr(4'(OPC_ADD + rand_below(4)), rand_reg(), rand_reg(), rand_reg()));
      end
      put_instr({OPC_HALT, 12'h000});
      repeat (5) put_instr(lbi_instr(rand_reg(), 9'(rand_below(512))));
   endtask

   task automatic illegal_program();
      new_program();
      seed_registers();
      put_instr(alu_instr(OPC_XOR, rand_reg(), rand_reg(), rand_reg()));
      put_instr({4'(9 + rand_below(6)), 12'(rand_below(4096))});
      repeat (4) begin
         put_instr(alu_instr(4'(OPC_ADD + rand_below(4)), rand_reg(), rand_reg(), rand_reg()));
      end
   endtask

   initial begin
      seed         = 32'ha9d9f9fc;
      arst_n       = 1'b0;
      error_count  = 0;
      test_count   = 0;
      failed_tests = 0;
      retire_count = 0;
      model_writes = 0;
      new_program();
      alu_program();
      run_test("alu_ops", 1'b0);
      immediate_program();
      run_test("immediates", 1'b0);
      forwarding_program();
      run_test("forwarding", 1'b0);
      memory_program();
      run_test("memory_load_use", 1'b0);
      halt_program();
      run_test("halt", 1'b0);
      illegal_program();
      run_test("illegal_opcode", 1'b1);
      if (mini_cpu_inst.mini_cpu_sva_inst.fail_count != 0) begin
         $display("%0d assertion failures in the pipeline checker",
                  mini_cpu_inst.mini_cpu_sva_inst.fail_count);
         error_count++;
      end
      $display("Tests run: %0d, tests failed: %0d, errors: %0d",
               test_count, failed_tests, error_count);
      if (error_count == 0 && failed_tests == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // Global limit in case a wait loop itself never returns
   initial begin
      #2000000;
      $display("Simulation time limit reached before the tests finished");
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
rtl/mini_cpu_pkg.sv
rtl/pipe_stage.sv
rtl/reg_file.sv
rtl/decode_unit.sv
rtl/hazard_unit.sv
rtl/execute_unit.sv
rtl/data_memory.sv
rtl/mini_cpu.sv
verification/mini_cpu_sva.sv
verification/mini_cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the mini_cpu testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f files.f --top-module mini_cpu_tb -o mini_cpu_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/mini_cpu_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
   echo "Simulation result: pass"
   exit 0
else
   echo "Simulation result: fail"
   exit 1
fi
